//--- logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

`define XLEN   32
`define REG_AW 5
`define RAM_AW 8        // 256 words
`define ALU_W  4

`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLT   4'd5
`define ALU_PASSB 4'd6  // lui

// Region code in address bits 31..29
`define MAP_RAM  3'b000
`define MAP_PWM  3'b001
`define MAP_LED  3'b010
`define MAP_GPIO 3'b011

// Word offset inside the PWM region, address bit 2
`define PWM_REG_PERIOD 1'b0
`define PWM_REG_DUTY   1'b1

`endif

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_params.svh"

package cpu_pkg;

    typedef logic [`XLEN-1:0]   word_t;      // Data and address word
    typedef logic [`REG_AW-1:0] reg_addr_t;
    typedef logic [`ALU_W-1:0]  alu_ctrl_t;
    typedef logic [5:0]         led_t;       // Six board LEDs

endpackage

`default_nettype wire

//--- logic/register_bank.sv
`timescale 1ns/10ps
`default_nettype none

module register_bank import cpu_pkg::*; (
    input  wire       clock,
    input  wire       rst,
    input  wire       enable,
    input  wire reg_addr_t rs1,
    input  wire reg_addr_t rs2,
    input  wire       write_enable,
    input  wire reg_addr_t write_address,
    input  wire word_t write_value,
    output word_t     rs1_value,
    output word_t     rs2_value
);

    word_t regs [1:31];     // x0 has no storage
    logic  writing;

    assign writing = enable && write_enable && write_address != '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writing) begin
            regs[write_address] <= write_value;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0)
            return '0;
        if (writing && addr == write_address)
            return write_value;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_value = read_port(rs1);
        rs2_value = read_port(rs2);
    end

endmodule

`default_nettype wire

//--- logic/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import cpu_pkg::*; (
    input  wire        clock,
    input  wire        rst,
    input  wire        enable,
    input  wire        stall,
    input  wire        branch_taken,
    input  wire word_t branch_target,
    output word_t      rom_address,
    input  wire word_t rom_data,
    output word_t      if_pc,
    output word_t      if_instr,
    output logic       if_valid
);

    word_t pc;

    assign rom_address = pc;    // ROM answers in the same cycle

    always_ff @(posedge clock) begin
        if (rst) begin
            pc       <= '0;
            if_valid <= 1'b0;
        end else if (enable) begin
            if (branch_taken) begin
                pc       <= branch_target;
                if_valid <= 1'b0;       // Squash the wrong-path fetch
            end else if (!stall) begin
                pc       <= pc + 32'd4;
                if_valid <= 1'b1;
            end
        end
    end

    // IF/ID payload, held while decode stalls
    always_ff @(posedge clock) begin
        if (enable && !stall && !branch_taken) begin
            if_pc    <= pc;
            if_instr <= rom_data;
        end
    end

    pc_aligned: assert property (@(posedge clock) disable iff (rst) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module decode_stage import cpu_pkg::*; (
    input  wire            clock,
    input  wire            rst,
    input  wire            enable,
    input  wire word_t     if_pc,
    input  wire word_t     if_instr,
    input  wire            if_valid,
    output reg_addr_t      rs1,
    output reg_addr_t      rs2,
    input  wire word_t     rs1_value,
    input  wire word_t     rs2_value,
    input  wire            ex_mem_read,
    input  wire reg_addr_t ex_rd,
    input  wire            branch_taken,
    output logic           stall,
    output logic           id_valid,
    output word_t          id_pc,
    output reg_addr_t      id_rs1,
    output reg_addr_t      id_rs2,
    output word_t          id_rs1_value,
    output word_t          id_rs2_value,
    output word_t          id_imm,
    output alu_ctrl_t      id_alu_ctrl,
    output logic           id_alu_src,
    output logic           id_mem_read,
    output logic           id_mem_write,
    output logic           id_reg_write,
    output reg_addr_t      id_rd,
    output logic           id_branch,
    output logic           id_branch_ne
);

    localparam logic [6:0] OP_R      = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    word_t      imm;
    alu_ctrl_t  alu_ctrl;
    alu_ctrl_t  arith_ctrl;
    logic       arith_ok;
    logic       supported;
    logic       alu_src;
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       branch;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       issue;

    assign opcode = if_instr[6:0];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];

    // Shared by register and immediate arithmetic
    always_comb begin
        arith_ok = 1'b1;
        case (funct3)
            3'b000:  arith_ctrl = (opcode == OP_R && if_instr[30]) ? `ALU_SUB : `ALU_ADD;
            3'b010:  arith_ctrl = `ALU_SLT;
            3'b100:  arith_ctrl = `ALU_XOR;
            3'b110:  arith_ctrl = `ALU_OR;
            3'b111:  arith_ctrl = `ALU_AND;
            default: begin
                arith_ctrl = `ALU_ADD;
                arith_ok   = 1'b0;
            end
        endcase
    end

    always_comb begin
        supported = 1'b0;
        alu_ctrl  = `ALU_ADD;
        alu_src   = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        branch    = 1'b0;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        imm       = {{20{if_instr[31]}}, if_instr[31:20]};     // I-type
        case (opcode)
            OP_R: begin
                supported = arith_ok;
                alu_ctrl  = arith_ctrl;
                alu_src   = 1'b0;
                reg_write = 1'b1;
                uses_rs2  = 1'b1;
            end
            OP_IMM: begin
                supported = arith_ok && funct3 != 3'b010;  // no slti
                alu_ctrl  = arith_ctrl;
                reg_write = 1'b1;
            end
            OP_LUI: begin
                supported = 1'b1;
                alu_ctrl  = `ALU_PASSB;
                reg_write = 1'b1;
                uses_rs1  = 1'b0;
                imm       = {if_instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                supported = funct3 == 3'b010;   // lw only
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OP_STORE: begin
                supported = funct3 == 3'b010;
                mem_write = 1'b1;
                uses_rs2  = 1'b1;
                imm       = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            end
            OP_BRANCH: begin
                supported = funct3[2:1] == 2'b00;   // beq, bne
                alu_src   = 1'b0;
                branch    = 1'b1;
                uses_rs2  = 1'b1;
                imm       = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                             if_instr[30:25], if_instr[11:8], 1'b0};
            end
            default: supported = 1'b0;
        endcase
    end

    // Load in execute feeding the instruction here
    assign stall = if_valid && id_mem_read && id_rd != '0 &&
                   ((uses_rs1 && id_rd == rs1) || (uses_rs2 && id_rd == rs2));

    assign issue = if_valid && supported && !stall && !branch_taken;

    always_ff @(posedge clock) begin
        if (rst) begin
            id_valid     <= 1'b0;
            id_mem_read  <= 1'b0;
            id_mem_write <= 1'b0;
            id_reg_write <= 1'b0;
            id_branch    <= 1'b0;
        end else if (enable) begin
            id_valid     <= issue;
            id_mem_read  <= issue && mem_read;
            id_mem_write <= issue && mem_write;
            id_reg_write <= issue && reg_write;
            id_branch    <= issue && branch;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            id_pc        <= if_pc;
            id_rs1       <= uses_rs1 ? rs1 : '0;    // Unused sources never forward
            id_rs2       <= uses_rs2 ? rs2 : '0;
            id_rs1_value <= rs1_value;
            id_rs2_value <= rs2_value;
            id_imm       <= imm;
            id_alu_ctrl  <= alu_ctrl;
            id_alu_src   <= alu_src;
            id_rd        <= if_instr[11:7];
            id_branch_ne <= funct3[0];
        end
    end

    // The stall keeps a consumer at least two slots behind its load
    no_load_use: assert property (@(posedge clock) disable iff (rst)
        ex_mem_read && ex_rd != '0 && id_valid |-> id_rs1 != ex_rd && id_rs2 != ex_rd);

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module execute_stage import cpu_pkg::*; (
    input  wire            clock,
    input  wire            rst,
    input  wire            enable,
    input  wire            id_valid,
    input  wire word_t     id_pc,
    input  wire reg_addr_t id_rs1,
    input  wire reg_addr_t id_rs2,
    input  wire word_t     id_rs1_value,
    input  wire word_t     id_rs2_value,
    input  wire word_t     id_imm,
    input  wire alu_ctrl_t id_alu_ctrl,
    input  wire            id_alu_src,
    input  wire            id_mem_read,
    input  wire            id_mem_write,
    input  wire            id_reg_write,
    input  wire reg_addr_t id_rd,
    input  wire            id_branch,
    input  wire            id_branch_ne,
    input  wire            wb_write_enable,
    input  wire reg_addr_t wb_rd,
    input  wire word_t     wb_value,
    output word_t          ex_result,
    output word_t          ex_store_value,
    output logic           ex_mem_read,
    output logic           ex_mem_write,
    output logic           ex_reg_write,
    output reg_addr_t      ex_rd,
    output logic           branch_taken,
    output word_t          branch_target
);

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_out;

    // Newest producer wins; a load in EX/MEM has no data yet
    function automatic word_t forward(reg_addr_t src, word_t reg_value);
        if (ex_reg_write && !ex_mem_read && ex_rd != '0 && ex_rd == src)
            return ex_result;
        if (wb_write_enable && wb_rd != '0 && wb_rd == src)
            return wb_value;
        return reg_value;
    endfunction

    always_comb begin
        op_a = forward(id_rs1, id_rs1_value);
        op_b = forward(id_rs2, id_rs2_value);
    end

    assign alu_b = id_alu_src ? id_imm : op_b;

    always_comb begin
        case (id_alu_ctrl)
            `ALU_SUB:   alu_out = op_a - alu_b;
            `ALU_AND:   alu_out = op_a & alu_b;
            `ALU_OR:    alu_out = op_a | alu_b;
            `ALU_XOR:   alu_out = op_a ^ alu_b;
            `ALU_SLT:   alu_out = word_t'($signed(op_a) < $signed(alu_b));
            `ALU_PASSB: alu_out = alu_b;
            default:    alu_out = op_a + alu_b;
        endcase
    end

    assign branch_taken  = id_valid && id_branch && ((op_a == op_b) != id_branch_ne);
    assign branch_target = id_pc + id_imm;

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (enable) begin
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
            ex_reg_write <= id_reg_write;
        end
    end

    always_ff @(posedge clock) begin
        if (enable) begin
            ex_result      <= alu_out;
            ex_store_value <= op_b;     // Forwarded store data
            ex_rd          <= id_rd;
        end
    end

endmodule

`default_nettype wire

//--- logic/memory_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module memory_stage import cpu_pkg::*; (
    input  wire            clock,
    input  wire            rst,
    input  wire            enable,
    input  wire word_t     ex_result,
    input  wire word_t     ex_store_value,
    input  wire            ex_mem_read,
    input  wire            ex_mem_write,
    input  wire            ex_reg_write,
    input  wire reg_addr_t ex_rd,
    output word_t          mem_addr,
    output word_t          mem_write_data,
    output logic           ram_write_enable,
    output logic           per_write_enable,
    input  wire word_t     ram_read_data,
    output logic           wb_write_enable,
    output reg_addr_t      wb_rd,
    output word_t          wb_value
);

    logic [2:0] region;
    word_t      load_data;

    assign region           = ex_result[31:29];
    assign mem_addr         = ex_result;
    assign mem_write_data   = ex_store_value;
    assign ram_write_enable = ex_mem_write && region == `MAP_RAM;
    assign per_write_enable = ex_mem_write && region != `MAP_RAM;
    assign load_data        = (region == `MAP_RAM) ? ram_read_data : '0;  // Peripherals read as zero

    always_ff @(posedge clock) begin
        if (rst)
            wb_write_enable <= 1'b0;
        else if (enable)
            wb_write_enable <= ex_reg_write;
    end

    // MEM/WB drives the register bank write port directly
    always_ff @(posedge clock) begin
        if (enable) begin
            wb_rd    <= ex_rd;
            wb_value <= ex_mem_read ? load_data : ex_result;
        end
    end

    load_xor_store: assert property (@(posedge clock) disable iff (rst)
        !(ex_mem_read && ex_mem_write));

endmodule

`default_nettype wire

//--- logic/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module data_ram import cpu_pkg::*; (
    input  wire        clock,
    input  wire        enable,
    input  wire word_t address,
    input  wire word_t write_data,
    input  wire        write_enable,
    output word_t      read_data
);

    word_t mem [0:(1 << `RAM_AW) - 1];
    logic [`RAM_AW-1:0] word_index;

    assign word_index = address[`RAM_AW+1:2];   // Byte address to word
    assign read_data  = mem[word_index];

    always_ff @(posedge clock) begin
        if (enable && write_enable)
            mem[word_index] <= write_data;
    end

endmodule

`default_nettype wire

//--- logic/peripheral_manager.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module peripheral_manager import cpu_pkg::*; (
    input  wire        clock,
    input  wire        rst,
    input  wire        enable,
    input  wire word_t address,
    input  wire word_t write_data,
    input  wire        write_enable,
    output led_t       led,
    output word_t      gpio_out,
    output logic       pwm1
);

    word_t period;
    word_t duty;
    word_t counter;

    always_ff @(posedge clock) begin
        if (rst) begin
            led      <= '0;
            gpio_out <= '0;
            period   <= '0;
            duty     <= '0;
        end else if (enable && write_enable) begin
            case (address[31:29])
                `MAP_LED:  led      <= write_data[5:0];
                `MAP_GPIO: gpio_out <= write_data;
                `MAP_PWM: begin
                    if (address[2] == `PWM_REG_DUTY)
                        duty <= write_data;
                    else
                        period <= write_data;
                end
                default: ;  // RAM region is not ours
            endcase
        end
    end

    // Free-running, ignores enable
    always_ff @(posedge clock) begin
        if (rst || period == '0 || counter >= period - 32'd1)
            counter <= '0;
        else
            counter <= counter + 32'd1;
    end

    assign pwm1 = period != '0 && counter < duty;

endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/10ps
`default_nettype none

module cpu import cpu_pkg::*; (
    input  wire        clock,
    input  wire        rst,
    input  wire        enable,
    input  wire word_t rom_data,
    output word_t      rom_address,
    output led_t       led,
    output word_t      gpio_out,
    output logic       port_pwm1
);

    // Fetch / decode
    word_t     if_pc;
    word_t     if_instr;
    logic      if_valid;
    logic      stall;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_value;
    word_t     rs2_value;

    // ID/EX
    logic      id_valid;
    word_t     id_pc;
    reg_addr_t id_rs1;
    reg_addr_t id_rs2;
    word_t     id_rs1_value;
    word_t     id_rs2_value;
    word_t     id_imm;
    alu_ctrl_t id_alu_ctrl;
    logic      id_alu_src;
    logic      id_mem_read;
    logic      id_mem_write;
    logic      id_reg_write;
    reg_addr_t id_rd;
    logic      id_branch;
    logic      id_branch_ne;

    // EX/MEM and branch redirect
    word_t     ex_result;
    word_t     ex_store_value;
    logic      ex_mem_read;
    logic      ex_mem_write;
    logic      ex_reg_write;
    reg_addr_t ex_rd;
    logic      branch_taken;
    word_t     branch_target;

    // Memory side and writeback
    word_t     mem_addr;
    word_t     mem_write_data;
    logic      ram_write_enable;
    logic      per_write_enable;
    word_t     ram_read_data;
    logic      wb_write_enable;
    reg_addr_t wb_rd;
    word_t     wb_value;

    // Stage ports share their names with the wires above
    fetch_stage fetch (.*);
    decode_stage decode (.*);
    execute_stage execute (.*);
    memory_stage memory (.*);

    register_bank regs (
        .clock         (clock),
        .rst           (rst),
        .enable        (enable),
        .rs1           (rs1),
        .rs2           (rs2),
        .write_enable  (wb_write_enable),
        .write_address (wb_rd),
        .write_value   (wb_value),
        .rs1_value     (rs1_value),
        .rs2_value     (rs2_value)
    );

    data_ram ram (
        .clock        (clock),
        .enable       (enable),
        .address      (mem_addr),
        .write_data   (mem_write_data),
        .write_enable (ram_write_enable),
        .read_data    (ram_read_data)
    );

    peripheral_manager periph (
        .clock        (clock),
        .rst          (rst),
        .enable       (enable),
        .address      (mem_addr),
        .write_data   (mem_write_data),
        .write_enable (per_write_enable),
        .led          (led),
        .gpio_out     (gpio_out),
        .pwm1         (port_pwm1)
    );

endmodule

`default_nettype wire

//--- verif/cpu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "cpu_params.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int TIMEOUT = 2000;
    localparam word_t NOP  = 32'h0000_0013;    // addi x0, x0, 0

    localparam int OP_IMM  = 'h13;
    localparam int OP_LOAD = 'h03;
    localparam int F3_ADD  = 0;
    localparam int F3_SLT  = 2;
    localparam int F3_XOR  = 4;
    localparam int F3_OR   = 6;
    localparam int F3_AND  = 7;
    localparam int F3_W    = 2;
    localparam int F3_BEQ  = 0;
    localparam int F3_BNE  = 1;

    // Upper 20 bits of each peripheral base as lui immediates
    localparam logic [19:0] GPIO_UP = {`MAP_GPIO, 17'd0};
    localparam logic [19:0] LED_UP  = {`MAP_LED, 17'd0};
    localparam logic [19:0] PWM_UP  = {`MAP_PWM, 17'd0};

    logic  clock;
    logic  rst;
    logic  enable;
    word_t rom_data;
    word_t rom_address;
    led_t  led;
    word_t gpio_out;
    logic  port_pwm1;

    word_t rom [0:255];
    int    prog_len;
    word_t rng_state = 32'h4b93;

    cpu uut (
        .clock       (clock),
        .rst         (rst),
        .enable      (enable),
        .rom_data    (rom_data),
        .rom_address (rom_address),
        .led         (led),
        .gpio_out    (gpio_out),
        .port_pwm1   (port_pwm1)
    );

    assign rom_data = rom[rom_address[9:2]];   // ROM answers in the same cycle

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic word_t xorshift32();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    function automatic word_t sext12(int x);
        return {{20{x[11]}}, x[11:0]};
    endfunction

    // RV32I encoders
    function automatic word_t r_type(int f3, int sub, int rd, int rs1, int rs2);
        return {1'b0, 1'(sub), 5'd0, 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'b0110011};
    endfunction

    function automatic word_t i_type(int opc, int f3, int rd, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(opc)};
    endfunction

    function automatic word_t s_type(int rs2, int rs1, int imm);
        logic [11:0] i;
        i = 12'(imm);
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int offset);
        logic [12:0] o;
        o = 13'(offset);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic word_t u_type(int rd, int upper);
        return {20'(upper), 5'(rd), 7'b0110111};
    endfunction

    task automatic abort_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(string test, word_t expected, word_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_led(string test, led_t expected, led_t actual);
        if (actual !== expected) begin
            $display("error: %s expected %h actual %h", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_bit(string test, logic expected, logic actual);
        if (actual !== expected) begin
            $display("error: %s expected %b actual %b", test, expected, actual);
            abort_run();
        end
    endtask

    task automatic emit(word_t instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    // Core held in reset while the new program goes in
    task automatic begin_program();
        @(posedge clock);
        rst    <= 1'b1;
        enable <= 1'b1;
        foreach (rom[i]) rom[i] = NOP;
        prog_len = 0;
    endtask

    task automatic start_program();
        repeat (2) @(posedge clock);
        rst <= 1'b0;
    endtask

    task automatic load_const(int rd, word_t value);
        word_t upper;
        upper = (value + 32'h800) >> 12;   // Rounded for the signed addi
        emit(u_type(rd, int'(upper)));
        emit(i_type(OP_IMM, F3_ADD, rd, rd, int'(value[11:0])));
    endtask

    task automatic emit_halt();
        emit(b_type(F3_BEQ, 0, 0, 0));
    endtask

    task automatic wait_gpio(string test, word_t expected);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (gpio_out !== expected && cycles < TIMEOUT);
        if (gpio_out !== expected)
            $display("%s: gpio_out never reached the expected value", test);
        check_word(test, expected, gpio_out);
    endtask

    // Counts x5 and x7 to n; the slots after each taken branch would corrupt them
    task automatic emit_count_loop(int n);
        emit(u_type(10, int'(GPIO_UP)));
        emit(u_type(11, int'(LED_UP)));
        emit(i_type(OP_IMM, F3_ADD, 5, 0, 0));
        emit(i_type(OP_IMM, F3_ADD, 6, 0, n));
        emit(i_type(OP_IMM, F3_ADD, 7, 0, 0));
        emit(i_type(OP_IMM, F3_ADD, 5, 5, 1));     // Loop top
        emit(i_type(OP_IMM, F3_ADD, 7, 7, 1));
        emit(b_type(F3_BEQ, 5, 6, 16));
        emit(b_type(F3_BNE, 5, 6, -12));
        emit(i_type(OP_IMM, F3_ADD, 5, 5, 100));   // Must never run
        emit(i_type(OP_IMM, F3_ADD, 7, 7, 50));
        emit(s_type(7, 11, 0));
        emit(s_type(5, 10, 0));
        emit_halt();
    endtask

    task automatic alu_forwarding();
        word_t a, b, e3, e4, e5, e6, e7, e8, e9, e13, e14, e15, e16, e17, e18, e19;
        int    i1, i2, i3, i4, up;
        a  = xorshift32();
        b  = xorshift32();
        i1 = int'(xorshift32() & 32'hfff);
        i2 = int'(xorshift32() & 32'hfff);
        i3 = int'(xorshift32() & 32'hfff);
        i4 = int'(xorshift32() & 32'hfff);
        up = int'(xorshift32() & 32'hfffff);
        e3  = a + b;
        e4  = e3 - a;
        e5  = e4 & e3;
        e6  = e5 | a;
        e7  = e6 ^ e3;
        e8  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        e9  = ($signed(e7) < $signed(e8)) ? 32'd1 : 32'd0;
        e13 = e7 + sext12(i1);
        e14 = word_t'(up) << 12;
        e15 = e13 ^ e14;
        e16 = e15 ^ sext12(i2);
        e17 = e16 | sext12(i3);
        e18 = e17 & sext12(i4);
        e19 = e18 + e15 + e8 + e9;

        begin_program();
        load_const(1, a);
        load_const(2, b);
        emit(r_type(F3_ADD, 0, 3, 1, 2));
        emit(r_type(F3_ADD, 1, 4, 3, 1));
        emit(r_type(F3_AND, 0, 5, 4, 3));
        emit(r_type(F3_OR, 0, 6, 5, 1));
        emit(r_type(F3_XOR, 0, 7, 6, 3));
        emit(r_type(F3_SLT, 0, 8, 1, 2));
        emit(r_type(F3_SLT, 0, 9, 7, 8));
        emit(i_type(OP_IMM, F3_ADD, 13, 7, i1));
        emit(u_type(14, up));
        emit(r_type(F3_XOR, 0, 15, 13, 14));
        emit(i_type(OP_IMM, F3_XOR, 16, 15, i2));
        emit(i_type(OP_IMM, F3_OR, 17, 16, i3));
        emit(i_type(OP_IMM, F3_AND, 18, 17, i4));
        emit(r_type(F3_ADD, 0, 19, 18, 15));
        emit(r_type(F3_ADD, 0, 19, 19, 8));
        emit(r_type(F3_ADD, 0, 19, 19, 9));
        emit(u_type(10, int'(GPIO_UP)));
        emit(s_type(19, 10, 0));
        emit_halt();
        start_program();
        wait_gpio("alu_forwarding", e19);
    endtask

    task automatic load_use_hazard();
        word_t r1, r2, r3, expected;
        int    base;
        r1   = xorshift32();
        r2   = xorshift32();
        r3   = xorshift32();
        base = int'(xorshift32() % 60) * 4;
        expected = (r3 - (r1 + r2)) ^ r2;

        begin_program();
        load_const(1, r1);
        load_const(2, r2);
        load_const(3, r3);
        emit(s_type(1, 0, base));
        emit(s_type(2, 0, base + 4));
        emit(s_type(3, 0, base + 8));
        emit(i_type(OP_LOAD, F3_W, 4, 0, base));
        emit(r_type(F3_ADD, 0, 5, 4, 0));           // Uses the load at once
        emit(i_type(OP_LOAD, F3_W, 6, 0, base + 4));
        emit(r_type(F3_ADD, 0, 5, 5, 6));
        emit(i_type(OP_LOAD, F3_W, 7, 0, base + 8));
        emit(r_type(F3_ADD, 1, 5, 7, 5));
        emit(i_type(OP_LOAD, F3_W, 8, 0, base + 4));
        emit(s_type(8, 0, base + 12));              // Loaded value as store data
        emit(i_type(OP_LOAD, F3_W, 9, 0, base + 12));
        emit(r_type(F3_XOR, 0, 5, 5, 9));
        emit(u_type(10, int'(GPIO_UP)));
        emit(s_type(5, 10, 0));
        emit_halt();
        start_program();
        wait_gpio("load_use_hazard", expected);
    endtask

    task automatic branch_flush();
        int n;
        n = 65 + int'(xorshift32() % 63);
        begin_program();
        emit_count_loop(n);
        start_program();
        wait_gpio("branch_flush", word_t'(n));
        check_led("branch_flush", led_t'(n % 64), led);
    endtask

    task automatic pwm_duty();
        int period, duty, high_count;
        period = 5 + int'(xorshift32() % 36);
        duty   = 1 + int'(xorshift32() % word_t'(period - 1));
        begin_program();
        emit(u_type(12, int'(PWM_UP)));
        emit(i_type(OP_IMM, F3_ADD, 1, 0, period));
        emit(i_type(OP_IMM, F3_ADD, 2, 0, duty));
        emit(s_type(2, 12, 4));
        emit(s_type(1, 12, 0));
        emit(u_type(10, int'(GPIO_UP)));
        emit(i_type(OP_IMM, F3_ADD, 3, 0, 1));
        emit(s_type(3, 10, 0));     // Done marker
        emit_halt();
        start_program();
        wait_gpio("pwm_duty", 32'd1);
        high_count = 0;
        repeat (period) begin
            @(negedge clock);
            if (port_pwm1)
                high_count++;
        end
        check_word("pwm_duty", word_t'(duty), word_t'(high_count));
    endtask

    task automatic zero_register();
        begin_program();
        emit(u_type(10, int'(GPIO_UP)));
        emit(i_type(OP_IMM, F3_ADD, 0, 0, 'h55));
        emit(u_type(0, 'habcde));
        emit(i_type(OP_IMM, F3_ADD, 1, 0, 'h5a));   // Reads x0 right after the writes
        emit(s_type(1, 10, 0));
        emit(s_type(0, 10, 0));
        emit_halt();
        start_program();
        @(negedge clock);
        check_led("reset_state", '0, led);
        check_word("reset_state", '0, gpio_out);
        check_bit("reset_state", 1'b0, port_pwm1);
        check_word("reset_state", '0, rom_address);
        wait_gpio("zero_register", 32'h5a);
        wait_gpio("zero_register", 32'h0);
    endtask

    task automatic enable_freeze();
        int    n;
        word_t held;
        n = 3 + int'(xorshift32() % 4);     // Loop would end inside the hold if not frozen
        begin_program();
        emit(u_type(10, int'(GPIO_UP)));
        emit(i_type(OP_IMM, F3_ADD, 1, 0, 'h77));
        emit(s_type(1, 10, 0));
        emit_count_loop(n);
        start_program();
        wait_gpio("enable_freeze", 32'h77);
        repeat (10) @(posedge clock);
        enable <= 1'b0;
        @(negedge clock);
        held = gpio_out;
        check_word("enable_freeze", 32'h77, held);
        repeat (50) begin
            @(negedge clock);
            check_word("enable_freeze", held, gpio_out);
        end
        @(posedge clock);
        enable <= 1'b1;
        wait_gpio("enable_freeze", word_t'(n));
        check_led("enable_freeze", led_t'(n % 64), led);
    endtask

    initial begin
        rst    <= 1'b1;
        enable <= 1'b1;
        foreach (rom[i]) rom[i] = NOP;
        prog_len = 0;
        repeat (3) alu_forwarding();
        repeat (2) load_use_hazard();
        branch_flush();
        pwm_duty();
        zero_register();    // Follows PWM so reset has something to clear
        enable_freeze();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+logic
logic/cpu_pkg.sv
logic/register_bank.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/data_ram.sv
logic/peripheral_manager.sv
logic/cpu.sv
verif/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
LINTFLAGS ?= --lint-only --timing --timescale 1ns/10ps
PASS_TEXT ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
